//--- ring_defs.svh
//**************************************************************************
// widths, depths and ring size shared by the package and the RTL
// ring_nodes must fit in ring_node_id_w bits
// fifo depths must stay below 2**ring_slots_w so the count can hold them
//**************************************************************************
`ifndef RING_DEFS_SVH
`define RING_DEFS_SVH

`define ring_flit_w      16  // flit payload bits
`define ring_node_id_w   4
`define ring_nodes       16  // nodes on the ring
`define ring_mem_aw      8   // 256 home words
`define ring_word_w      32  // one word = two flits

// fifo sizes
`define ring_local_depth 8
`define ring_pass_depth  8
`define ring_slots_w     4   // occupancy count, 0..depth

`endif

//--- verilog/ring_pkg.sv
//**************************************************************************
// one link format serves both directions of the ring
// head flit layout is cmd, dst, src from the top bit down, rest zero
//**************************************************************************
`default_nettype none

`include "ring_defs.svh"

package ring_pkg;

  typedef logic [`ring_flit_w-1:0]    flit_t;
  typedef logic [`ring_node_id_w-1:0] node_id_t;
  typedef logic [`ring_word_w-1:0]    word_t;
  typedef logic [`ring_mem_aw-1:0]    mem_addr_t;
  typedef logic [`ring_slots_w-1:0]   slots_t;

  // framing carried beside every flit
  typedef enum logic [1:0] {
    none = 2'b00,
    head = 2'b01,
    body = 2'b10,
    tail = 2'b11  // also the single-flit write ack
  } flit_kind_e;

  typedef enum logic {
    dest_local = 1'b0,  // consumed by the receiving node
    dest_pass  = 1'b1   // forwarded by the receiving node
  } dest_fifo_e;

  typedef enum logic [1:0] {
    read_req  = 2'b00,
    write_req = 2'b01,
    read_rep  = 2'b10,
    write_ack = 2'b11
  } msg_cmd_e;

  typedef struct packed {
    flit_kind_e kind;
    dest_fifo_e dest;
    flit_t      flit;
  } ring_link_t;

  typedef struct packed {
    msg_cmd_e cmd;
    node_id_t dst;
    node_id_t src;
    logic [`ring_flit_w-2-2*`ring_node_id_w-1:0] pad;  // always zero
  } head_flit_t;

  // reply from home memory to the uploader
  typedef struct packed {
    msg_cmd_e cmd;
    node_id_t dst;   // requester
    node_id_t src;   // this home node
    word_t    data;  // read data, ignored on write ack
  } rep_msg_t;

  typedef enum logic [2:0] {
    hs_head,
    hs_addr_hi,
    hs_addr_lo,
    hs_data_hi,
    hs_data_lo,
    hs_drop     // skipping a stray reply packet
  } home_state_e;

  typedef enum logic [1:0] {
    us_idle,
    us_head,
    us_data_hi,
    us_data_lo
  } upload_state_e;

endpackage

`default_nettype wire

//--- verilog/flit_fifo.sv
//**************************************************************************
// circular fifo of ring links, head valid while count is non-zero
// a push into a full fifo is dropped, so senders must watch not_full
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ring_defs.svh"

module flit_fifo #(
  parameter int depth = `ring_local_depth
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  push,
  input  wire ring_pkg::ring_link_t push_link,
  input  wire                  pop,
  output ring_pkg::ring_link_t head_link,
  output ring_pkg::slots_t     count,
  output logic                 not_full
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  ring_pkg::ring_link_t mem [depth];  // no reset on storage
  logic [aw-1:0] wr_ptr, rd_ptr;
  logic do_push, do_pop;

  assign not_full  = (count != ring_pkg::slots_t'(depth));
  assign do_push   = push && not_full;
  assign do_pop    = pop && (count != '0);  // pop on empty is ignored
  assign head_link = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap at depth
      if (do_pop)
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_link;
  end

endmodule

`default_nettype wire

//--- verilog/home_memory.sv
//**************************************************************************
// home memory: collects request flits, reads or writes on the tail flit
// only the low ring_mem_aw address bits index the array
// reply packets arriving here are thrown away up to their tail
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module home_memory #(
  parameter ring_pkg::node_id_t node_id = '0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire ring_pkg::ring_link_t req_link,   // local fifo head
  input  wire ring_pkg::slots_t     req_count,
  output logic                 req_pop,
  output logic                 rep_valid,  // held until rep_take
  output ring_pkg::rep_msg_t   rep_msg,
  input  wire                  rep_take
);

  ring_pkg::home_state_e state;
  ring_pkg::msg_cmd_e    cmd_q;
  ring_pkg::node_id_t    src_q;       // requester
  ring_pkg::flit_t       addr_hi_q;
  ring_pkg::flit_t       data_hi_q;
  ring_pkg::mem_addr_t   addr_q;      // write address, held for the data flits
  ring_pkg::word_t       mem [2**$bits(ring_pkg::mem_addr_t)];
  ring_pkg::head_flit_t  hdr;
  ring_pkg::mem_addr_t   cur_addr;
  ring_pkg::word_t       wr_word;
  logic                  is_req;

  assign hdr      = ring_pkg::head_flit_t'(req_link.flit);
  assign is_req   = (hdr.cmd == ring_pkg::read_req) || (hdr.cmd == ring_pkg::write_req);
  assign cur_addr = ring_pkg::mem_addr_t'({addr_hi_q, req_link.flit});  // truncate to index
  assign wr_word  = {data_hi_q, req_link.flit};

  // one flit per cycle, stalled while a reply is still waiting
  assign req_pop = (req_count != '0) && !rep_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ring_pkg::hs_head;
      rep_valid <= 1'b0;
    end else begin
      if (rep_take)
        rep_valid <= 1'b0;
      if (req_pop) begin
        case (state)
          ring_pkg::hs_head: begin
            if (req_link.kind == ring_pkg::head)  // lone tail or stray body stays here
              state <= is_req ? ring_pkg::hs_addr_hi : ring_pkg::hs_drop;
          end
          ring_pkg::hs_addr_hi: state <= ring_pkg::hs_addr_lo;
          ring_pkg::hs_addr_lo: begin
            if (cmd_q == ring_pkg::read_req) begin
              state     <= ring_pkg::hs_head;  // address low is the read tail
              rep_valid <= 1'b1;
            end else begin
              state <= ring_pkg::hs_data_hi;
            end
          end
          ring_pkg::hs_data_hi: state <= ring_pkg::hs_data_lo;
          ring_pkg::hs_data_lo: begin
            state     <= ring_pkg::hs_head;
            rep_valid <= 1'b1;
          end
          ring_pkg::hs_drop: begin
            if (req_link.kind == ring_pkg::tail)
              state <= ring_pkg::hs_head;
          end
          default: state <= ring_pkg::hs_head;
        endcase
      end
    end
  end

  // payload registers and the word array
  always_ff @(posedge clk) begin
    if (req_pop) begin
      case (state)
        ring_pkg::hs_head: begin
          cmd_q <= hdr.cmd;
          src_q <= hdr.src;
        end
        ring_pkg::hs_addr_hi: addr_hi_q <= req_link.flit;
        ring_pkg::hs_addr_lo: begin
          addr_q <= cur_addr;
          if (cmd_q == ring_pkg::read_req) begin
            rep_msg.cmd  <= ring_pkg::read_rep;
            rep_msg.dst  <= src_q;
            rep_msg.src  <= node_id;
            rep_msg.data <= mem[cur_addr];  // asynchronous array read
          end
        end
        ring_pkg::hs_data_hi: data_hi_q <= req_link.flit;
        ring_pkg::hs_data_lo: begin
          mem[addr_q]  <= wr_word;
          rep_msg.cmd  <= ring_pkg::write_ack;
          rep_msg.dst  <= src_q;
          rep_msg.src  <= node_id;
          rep_msg.data <= wr_word;  // echoed, not sent on the ring
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/rep_upload.sv
//**************************************************************************
// reply uploader, parallel to serial
// read reply leaves as head, data high, data low; write ack as one tail flit
// dest is left as dest_pass, the link arbiter writes the real next hop
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module rep_upload (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  rep_valid,
  input  wire ring_pkg::rep_msg_t   rep_msg,
  output logic                 rep_take,  // one-cycle pulse, idle only
  output logic                 up_req,    // a flit is offered on up_link
  output ring_pkg::ring_link_t up_link,
  input  wire                  up_grant   // consumes the offered flit
);

  ring_pkg::upload_state_e state;
  ring_pkg::rep_msg_t      msg_q;
  ring_pkg::head_flit_t    hdr;
  ring_pkg::flit_t         data_hi, data_lo;
  logic                    single;  // write ack, one flit only

  assign rep_take = (state == ring_pkg::us_idle) && rep_valid;
  assign up_req   = (state != ring_pkg::us_idle);
  assign single   = (msg_q.cmd == ring_pkg::write_ack);
  assign {data_hi, data_lo} = msg_q.data;

  assign hdr.cmd = msg_q.cmd;
  assign hdr.dst = msg_q.dst;
  assign hdr.src = msg_q.src;
  assign hdr.pad = '0;

  always_comb begin
    up_link.dest = ring_pkg::dest_pass;
    case (state)
      ring_pkg::us_head: begin
        up_link.kind = single ? ring_pkg::tail : ring_pkg::head;
        up_link.flit = hdr;
      end
      ring_pkg::us_data_hi: begin
        up_link.kind = ring_pkg::body;
        up_link.flit = data_hi;
      end
      ring_pkg::us_data_lo: begin
        up_link.kind = ring_pkg::tail;
        up_link.flit = data_lo;
      end
      default: begin
        up_link.kind = ring_pkg::none;
        up_link.flit = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ring_pkg::us_idle;
    end else begin
      case (state)
        ring_pkg::us_idle:
          if (rep_valid) state <= ring_pkg::us_head;
        ring_pkg::us_head:
          if (up_grant) state <= single ? ring_pkg::us_idle : ring_pkg::us_data_hi;
        ring_pkg::us_data_hi:
          if (up_grant) state <= ring_pkg::us_data_lo;
        default:  // data low, last flit
          if (up_grant) state <= ring_pkg::us_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rep_take)
      msg_q <= rep_msg;
  end

endmodule

`default_nettype wire

//--- verilog/link_arbiter.sv
//**************************************************************************
// output link arbiter between the pass fifo and the reply uploader
// grant is held from head to tail, priority alternates between packets
// a flit leaves only while the next node's matching enable is high
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ring_defs.svh"

module link_arbiter #(
  parameter ring_pkg::node_id_t node_id = '0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire ring_pkg::ring_link_t pass_link,   // pass fifo head
  input  wire ring_pkg::slots_t     pass_count,
  output logic                 pass_pop,
  input  wire                  up_req,
  input  wire ring_pkg::ring_link_t up_link,
  output logic                 up_grant,
  input  wire                  en_local_in,
  input  wire                  en_pass_in,
  output ring_pkg::ring_link_t out_link
);

  // next node id, modulo ring size
  localparam ring_pkg::node_id_t next_id =
    (node_id == `ring_nodes - 1) ? '0 : node_id + 1'b1;

  logic locked;  // inside a packet
  logic sel_q;   // locked source, 1 = uploader
  logic prio_q;  // 0 favours pass between packets
  ring_pkg::dest_fifo_e dest_q;
  ring_pkg::dest_fifo_e hop_dest, cur_dest;
  ring_pkg::ring_link_t cur_link;
  ring_pkg::head_flit_t hdr;
  logic pass_avail, cur_sel, cur_valid, dest_ok, fire;

  assign pass_avail = (pass_count != '0);
  assign cur_sel    = locked ? sel_q : (up_req && (prio_q || !pass_avail));
  assign cur_link   = cur_sel ? up_link : pass_link;
  assign cur_valid  = cur_sel ? up_req : pass_avail;

  // next hop from the head's destination node, only meaningful on a head
  assign hdr      = ring_pkg::head_flit_t'(cur_link.flit);
  assign hop_dest = (hdr.dst == next_id) ? ring_pkg::dest_local : ring_pkg::dest_pass;
  assign cur_dest = locked ? dest_q : hop_dest;

  assign dest_ok  = (cur_dest == ring_pkg::dest_local) ? en_local_in : en_pass_in;
  assign fire     = cur_valid && dest_ok;  // back-pressure gate
  assign pass_pop = fire && !cur_sel;
  assign up_grant = fire && cur_sel;

  always_comb begin
    if (fire) begin
      out_link.kind = cur_link.kind;
      out_link.dest = cur_dest;
      out_link.flit = cur_link.flit;
    end else begin
      out_link.kind = ring_pkg::none;  // idle link
      out_link.dest = ring_pkg::dest_pass;
      out_link.flit = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked <= 1'b0;
      sel_q  <= 1'b0;
      prio_q <= 1'b0;  // pass goes first
      dest_q <= ring_pkg::dest_pass;
    end else if (fire) begin
      if (cur_link.kind == ring_pkg::tail) begin
        locked <= 1'b0;     // also covers the single-flit ack
        prio_q <= ~prio_q;
      end else if (!locked) begin
        locked <= 1'b1;
        sel_q  <= cur_sel;
        dest_q <= hop_dest;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ring_node.sv
//**************************************************************************
// one ring node: local and pass fifos, home memory and reply uploader
// enables to the previous node are free-slot levels of the two fifos
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ring_defs.svh"

module ring_node #(
  parameter ring_pkg::node_id_t node_id = '0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire ring_pkg::ring_link_t in_link,      // from previous node
  input  wire                  en_local_in,  // next node local fifo has room
  input  wire                  en_pass_in,   // next node pass fifo has room
  output ring_pkg::ring_link_t out_link,
  output logic                 en_local,     // to previous node
  output logic                 en_pass,
  output ring_pkg::slots_t     used_slots_pass
);

  ring_pkg::ring_link_t local_head, pass_head, up_link;
  ring_pkg::slots_t     local_count;
  ring_pkg::rep_msg_t   rep_msg;
  logic push_local, push_pass;
  logic local_pop, pass_pop;
  logic rep_valid, rep_take;
  logic up_req, up_grant;

  // steer by the dest field the previous node wrote
  assign push_local = (in_link.kind != ring_pkg::none) && (in_link.dest == ring_pkg::dest_local);
  assign push_pass  = (in_link.kind != ring_pkg::none) && (in_link.dest == ring_pkg::dest_pass);

  flit_fifo #(.depth(`ring_local_depth)) u_local_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(push_local), .push_link(in_link),
    .pop(local_pop), .head_link(local_head),
    .count(local_count), .not_full(en_local)
  );

  flit_fifo #(.depth(`ring_pass_depth)) u_pass_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(push_pass), .push_link(in_link),
    .pop(pass_pop), .head_link(pass_head),
    .count(used_slots_pass), .not_full(en_pass)
  );

  home_memory #(.node_id(node_id)) u_home_memory (
    .clk(clk), .rst_n(rst_n),
    .req_link(local_head), .req_count(local_count), .req_pop(local_pop),
    .rep_valid(rep_valid), .rep_msg(rep_msg), .rep_take(rep_take)
  );

  rep_upload u_rep_upload (
    .clk(clk), .rst_n(rst_n),
    .rep_valid(rep_valid), .rep_msg(rep_msg), .rep_take(rep_take),
    .up_req(up_req), .up_link(up_link), .up_grant(up_grant)
  );

  link_arbiter #(.node_id(node_id)) u_link_arbiter (
    .clk(clk), .rst_n(rst_n),
    .pass_link(pass_head), .pass_count(used_slots_pass), .pass_pop(pass_pop),
    .up_req(up_req), .up_link(up_link), .up_grant(up_grant),
    .en_local_in(en_local_in), .en_pass_in(en_pass_in),
    .out_link(out_link)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
//**************************************************************************
// testbench clock and reset, reset released just after a rising edge
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period       = 20,  // ns
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;  // clear of the edge
  end

endmodule

`default_nettype wire

//--- bench/ring_node_properties.sv
//**************************************************************************
// link rules checked on the arbiter output, bound into link_arbiter
// a lone tail on the link is a write ack and is legal outside a packet
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ring_defs.svh"

module ring_node_properties (
  input wire                       clk,
  input wire                       rst_n,
  input wire ring_pkg::ring_link_t out_link,
  input wire                       en_local_in,
  input wire                       en_pass_in,
  input wire ring_pkg::slots_t     pass_count
);

  logic in_pkt;  // a head has left, its tail not yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      in_pkt <= 1'b0;
    else if (out_link.kind == ring_pkg::head)
      in_pkt <= 1'b1;
    else if (out_link.kind == ring_pkg::tail)
      in_pkt <= 1'b0;
  end

  a_body_in_pkt: assert property (@(posedge clk) disable iff (!rst_n)
    (out_link.kind == ring_pkg::body) |-> in_pkt)
    else $error("body flit left without a head before it");

  a_head_outside: assert property (@(posedge clk) disable iff (!rst_n)
    (out_link.kind == ring_pkg::head) |-> !in_pkt)
    else $error("head flit left inside an open packet");

  // back-pressure, the next node must have room in the named fifo
  a_enable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_link.kind != ring_pkg::none) |->
      ((out_link.dest == ring_pkg::dest_local) ? en_local_in : en_pass_in))
    else $error("flit left while the next node enable was low");

  a_pass_bound: assert property (@(posedge clk) disable iff (!rst_n)
    pass_count <= `ring_pass_depth)
    else $error("pass fifo count above its depth");

endmodule

bind link_arbiter ring_node_properties u_properties (
  .clk(clk), .rst_n(rst_n), .out_link(out_link),
  .en_local_in(en_local_in), .en_pass_in(en_pass_in), .pass_count(pass_count)
);

`default_nettype wire

//--- bench/ring_node_tb.sv
//**************************************************************************
// directed tests of one ring node with node id 3, next node is 4
// out_link is sampled mid-cycle; waits on the uploader through UUT.up_req
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ring_defs.svh"

module ring_node_tb;

  localparam ring_pkg::node_id_t node_id = 4'd3;
  localparam int wait_limit = 200;  // cycles per wait loop

  logic clk, rst_n;
  logic en_local_in, en_pass_in, en_local, en_pass;
  ring_pkg::ring_link_t in_link, out_link;
  ring_pkg::slots_t     used_slots_pass;

  ring_pkg::ring_link_t mon_q [$];  // flits seen leaving
  ring_pkg::ring_link_t exp_q [$];
  ring_pkg::word_t shadow [2**`ring_mem_aw];  // last word written per index
  bit              written [2**`ring_mem_aw];
  int checks, errors, test_errors;
  int pkts_out;  // packets expected to have left so far

  tb_clock_gen #(.period(20), .reset_cycles(4)) u_clock (.clk(clk), .rst_n(rst_n));

  ring_node #(.node_id(node_id)) UUT (
    .clk(clk), .rst_n(rst_n), .in_link(in_link),
    .en_local_in(en_local_in), .en_pass_in(en_pass_in),
    .out_link(out_link), .en_local(en_local), .en_pass(en_pass),
    .used_slots_pass(used_slots_pass)
  );

  // a flit shown here is taken at the next rising edge
  always @(negedge clk) begin
    if (rst_n && out_link.kind != ring_pkg::none)
      mon_q.push_back(out_link);
  end

  function automatic ring_pkg::flit_t head_flit(input ring_pkg::msg_cmd_e cmd,
      input ring_pkg::node_id_t dst, input ring_pkg::node_id_t src);
    return {cmd, dst, src, {(`ring_flit_w - 2 - 2*`ring_node_id_w){1'b0}}};
  endfunction

  // local only when the packet ends at the next node
  function automatic ring_pkg::dest_fifo_e next_hop(input ring_pkg::node_id_t dst);
    ring_pkg::node_id_t next_id;
    next_id = ring_pkg::node_id_t'((int'(node_id) + 1) % `ring_nodes);
    return (dst == next_id) ? ring_pkg::dest_local : ring_pkg::dest_pass;
  endfunction

  function automatic ring_pkg::flit_kind_e kind_at(input int i, input int len);
    if (i == 0) return ring_pkg::head;
    return (i == len - 1) ? ring_pkg::tail : ring_pkg::body;
  endfunction

  function automatic ring_pkg::flit_t pass_flit(input ring_pkg::node_id_t dst, input int i);
    if (i == 0) return head_flit(ring_pkg::write_req, dst, 4'd11);
    return ring_pkg::flit_t'(16'ha500 + i);  // body pattern
  endfunction

  task automatic check_flit(input string name, input ring_pkg::flit_t got,
                            input ring_pkg::flit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_link_kind(input string name, input ring_pkg::flit_kind_e got,
                                 input ring_pkg::flit_kind_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dest(input string name, input ring_pkg::dest_fifo_e got,
                            input ring_pkg::dest_fifo_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_slots(input string name, input ring_pkg::slots_t got,
                             input ring_pkg::slots_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0)
      $display("test %-14s ok", name);
    else
      $display("test %-14s %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // drive one flit at the current step, held until the next rising edge
  task automatic send_flit(input ring_pkg::flit_kind_e kind, input ring_pkg::dest_fifo_e dest,
                           input ring_pkg::flit_t flit);
    int waited;
    waited = 0;
    while (!((dest == ring_pkg::dest_local) ? en_local : en_pass) && waited < wait_limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (waited >= wait_limit) abort_on_timeout("a free slot in the input fifo");
    in_link.kind = kind;
    in_link.dest = dest;
    in_link.flit = flit;
    @(posedge clk);
    #2;
    in_link.kind = ring_pkg::none;
  endtask

  task automatic wait_out_flits(input int n, input string what);
    int waited;
    waited = 0;
    while (mon_q.size() < n && waited < wait_limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (mon_q.size() < n) abort_on_timeout(what);
  endtask

  task automatic expect_flit(input ring_pkg::flit_kind_e kind, input ring_pkg::dest_fifo_e dest,
                             input ring_pkg::flit_t flit);
    ring_pkg::ring_link_t lnk;
    lnk.kind = kind;
    lnk.dest = dest;
    lnk.flit = flit;
    exp_q.push_back(lnk);
  endtask

  task automatic expect_ack(input ring_pkg::node_id_t src);
    expect_flit(ring_pkg::tail, next_hop(src), head_flit(ring_pkg::write_ack, src, node_id));
  endtask

  task automatic expect_read_rep(input ring_pkg::node_id_t src, input ring_pkg::word_t word);
    expect_flit(ring_pkg::head, next_hop(src), head_flit(ring_pkg::read_rep, src, node_id));
    expect_flit(ring_pkg::body, next_hop(src), word[2*`ring_flit_w-1:`ring_flit_w]);
    expect_flit(ring_pkg::tail, next_hop(src), word[`ring_flit_w-1:0]);
  endtask

  task automatic expect_pass_pkt(input ring_pkg::node_id_t dst, input int len);
    for (int i = 0; i < len; i++)
      expect_flit(kind_at(i, len), next_hop(dst), pass_flit(dst, i));
  endtask

  task automatic send_write(input ring_pkg::node_id_t src, input ring_pkg::flit_t addr_hi,
                            input ring_pkg::flit_t addr_lo, input ring_pkg::word_t word);
    send_flit(ring_pkg::head, ring_pkg::dest_local, head_flit(ring_pkg::write_req, node_id, src));
    send_flit(ring_pkg::body, ring_pkg::dest_local, addr_hi);
    send_flit(ring_pkg::body, ring_pkg::dest_local, addr_lo);
    send_flit(ring_pkg::body, ring_pkg::dest_local, word[2*`ring_flit_w-1:`ring_flit_w]);
    send_flit(ring_pkg::tail, ring_pkg::dest_local, word[`ring_flit_w-1:0]);
    shadow[addr_lo[`ring_mem_aw-1:0]]  = word;  // only the low bits index the array
    written[addr_lo[`ring_mem_aw-1:0]] = 1'b1;
  endtask

  task automatic send_read(input ring_pkg::node_id_t src, input ring_pkg::flit_t addr_hi,
                           input ring_pkg::flit_t addr_lo);
    send_flit(ring_pkg::head, ring_pkg::dest_local, head_flit(ring_pkg::read_req, node_id, src));
    send_flit(ring_pkg::body, ring_pkg::dest_local, addr_hi);
    send_flit(ring_pkg::tail, ring_pkg::dest_local, addr_lo);
  endtask

  task automatic compare_output();
    int n;
    ring_pkg::ring_link_t got, exp;
    n = (mon_q.size() < exp_q.size()) ? mon_q.size() : exp_q.size();
    if (mon_q.size() != exp_q.size()) begin
      errors++;
      test_errors++;
      $display("out_link carried %0d flits where %0d were expected", mon_q.size(), exp_q.size());
    end
    for (int i = 0; i < n; i++) begin
      got = mon_q[i];
      exp = exp_q[i];
      check_link_kind($sformatf("out_link.kind[%0d]", i), got.kind, exp.kind);
      check_dest($sformatf("out_link.dest[%0d]", i), got.dest, exp.dest);
      check_flit($sformatf("out_link.flit[%0d]", i), got.flit, exp.flit);
    end
    foreach (exp_q[i])
      if (exp_q[i].kind == ring_pkg::tail)
        pkts_out++;  // every packet ends in one tail
    mon_q.delete();
    exp_q.delete();
  endtask

  task automatic test_reset();
    check_level("en_local", en_local, 1'b1);
    check_level("en_pass", en_pass, 1'b1);
    check_link_kind("out_link.kind", out_link.kind, ring_pkg::none);
    check_slots("used_slots_pass", used_slots_pass, ring_pkg::slots_t'(0));
    end_test("reset");
  endtask

  task automatic test_write_read();
    expect_ack(4'd7);
    send_write(4'd7, 16'h1234, 16'h0045, 32'hcafe_f00d);  // high address bits ignored
    wait_out_flits(1, "the write ack");
    compare_output();
    expect_read_rep(4'd7, shadow[8'h45]);
    send_read(4'd7, 16'h0000, 16'h0045);
    wait_out_flits(3, "the read reply to node 7");
    compare_output();
    expect_read_rep(4'd4, shadow[8'h45]);  // reply to the next node goes local
    send_read(4'd4, 16'h00ff, 16'hff45);
    wait_out_flits(3, "the read reply to node 4");
    compare_output();
    end_test("write_read");
  endtask

  task automatic test_pass_through();
    ring_pkg::node_id_t dsts [2];
    dsts[0] = 4'd9;
    dsts[1] = 4'd4;
    foreach (dsts[k]) begin
      expect_pass_pkt(dsts[k], 5);
      for (int i = 0; i < 5; i++)
        send_flit(kind_at(i, 5), ring_pkg::dest_pass, pass_flit(dsts[k], i));
      wait_out_flits(5, "the pass-through packet");
      compare_output();
    end
    end_test("pass_through");
  endtask

  task automatic test_back_pressure();
    en_pass_in = 1'b0;
    expect_pass_pkt(4'd9, 8);
    for (int i = 0; i < 8; i++)
      send_flit(kind_at(i, 8), ring_pkg::dest_pass, pass_flit(4'd9, i));
    check_slots("used_slots_pass", used_slots_pass, ring_pkg::slots_t'(8));
    check_level("en_pass", en_pass, 1'b0);
    check_link_kind("out_link.kind", out_link.kind, ring_pkg::none);
    if (mon_q.size() != 0) begin
      errors++;
      test_errors++;
      $display("flits left the node while the next pass fifo was closed");
    end
    en_pass_in = 1'b1;
    wait_out_flits(8, "the pass fifo to drain");
    compare_output();
    @(posedge clk);
    #2;
    check_slots("used_slots_pass", used_slots_pass, ring_pkg::slots_t'(0));
    check_level("en_pass", en_pass, 1'b1);
    end_test("back_pressure");
  endtask

  task automatic test_atomicity();
    int waited;
    ring_pkg::flit_t req [3];
    req[0] = head_flit(ring_pkg::read_req, node_id, 4'd7);
    req[1] = 16'h0000;
    req[2] = 16'h0045;
    en_pass_in = 1'b0;  // both packets queue up behind the closed link
    for (int i = 0; i < 5; i++) begin
      send_flit(kind_at(i, 5), ring_pkg::dest_pass, pass_flit(4'd9, i));
      if (i < 3)
        send_flit(kind_at(i, 3), ring_pkg::dest_local, req[i]);
    end
    waited = 0;
    while (!UUT.up_req && waited < wait_limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!UUT.up_req) abort_on_timeout("the uploader to offer the read reply");
    check_slots("used_slots_pass", used_slots_pass, ring_pkg::slots_t'(5));
    en_pass_in = 1'b1;
    wait_out_flits(8, "both packets to leave");
    if (pkts_out % 2 == 0) begin  // priority flips per packet, pass first after an even count
      expect_pass_pkt(4'd9, 5);
      expect_read_rep(4'd7, shadow[8'h45]);
    end else begin
      expect_read_rep(4'd7, shadow[8'h45]);
      expect_pass_pkt(4'd9, 5);
    end
    compare_output();
    end_test("atomicity");
  endtask

  task automatic test_random_words();
    ring_pkg::node_id_t src;
    ring_pkg::flit_t    addr_lo;
    ring_pkg::word_t    word;
    ring_pkg::mem_addr_t idx;
    for (int n = 0; n < 12; n++) begin
      src     = ring_pkg::node_id_t'($urandom);
      word    = ring_pkg::word_t'($urandom);
      addr_lo = ring_pkg::flit_t'($urandom);
      addr_lo[`ring_mem_aw-1:0] = ring_pkg::mem_addr_t'(32'h80 + $urandom % 8);  // repeats likely
      expect_ack(src);
      send_write(src, ring_pkg::flit_t'($urandom), addr_lo, word);
      wait_out_flits(1, "a random write ack");
      compare_output();
    end
    for (int a = 0; a < 8; a++) begin
      idx = ring_pkg::mem_addr_t'(32'h80 + a);
      if (written[idx]) begin
        src     = ring_pkg::node_id_t'($urandom);
        addr_lo = ring_pkg::flit_t'($urandom);
        addr_lo[`ring_mem_aw-1:0] = idx;
        expect_read_rep(src, shadow[idx]);
        send_read(src, ring_pkg::flit_t'($urandom), addr_lo);
        wait_out_flits(3, "a random read reply");
        compare_output();
      end
    end
    end_test("random_words");
  endtask

  initial begin
    int waited;
    in_link     = '0;
    en_local_in = 1'b1;
    en_pass_in  = 1'b1;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    pkts_out    = 0;
    void'($urandom(32'h52e8));  // one seed for the whole run
    waited = 0;
    while (rst_n !== 1'b1 && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) abort_on_timeout("reset release");
    @(posedge clk);
    #2;
    test_reset();
    test_write_read();
    test_pass_through();
    test_back_pressure();
    test_atomicity();
    test_random_words();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
verilog/ring_pkg.sv
verilog/flit_fifo.sv
verilog/home_memory.sv
verilog/rep_upload.sv
verilog/link_arbiter.sv
verilog/ring_node.sv
bench/tb_clock_gen.sv
bench/ring_node_properties.sv
bench/ring_node_tb.sv

//--- Bender.yml
package:
  name: ring_node

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - verilog/ring_pkg.sv
      - verilog/flit_fifo.sv
      - verilog/home_memory.sv
      - verilog/rep_upload.sv
      - verilog/link_arbiter.sv
      - verilog/ring_node.sv
  - target: test
    include_dirs:
      - .
    files:
      - bench/tb_clock_gen.sv
      - bench/ring_node_properties.sv
      - bench/ring_node_tb.sv
